// ==== sim.f ====
+incdir+.
ecc_pkg.sv
ecc_encoder.sv
ecc_syndrome_decoder.sv
ecc_89_top.sv
tb_ecc.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ECC testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_ecc -f sim.f -o Vtb_ecc

output=$(./obj_dir/Vtb_ecc)
echo "$output"

if echo "$output" | grep -qF '** PASS **'; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// ==== tb_ecc_model.svh ====
`ifndef TB_ECC_MODEL_SVH
`define TB_ECC_MODEL_SVH

// Data bits sit at 0..88 and check bits 0..7 at 89..96
localparam int CW_WIDTH = ecc_pkg::DATA_WIDTH + ecc_pkg::PARITY_WIDTH;

// Expected check bits as the sum of the columns of all set data bits
function automatic ecc_pkg::parity_t model_parity(input ecc_pkg::data_t d);
    ecc_pkg::parity_t p;

    p = '0;
    for (int i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin
        if (d[i]) begin
            p = p ^ ecc_pkg::H_COLUMNS[i];
        end
    end
    return p;
endfunction

// Builds the received word from the flip positions and predicts
// every decoder output from what was flipped
task automatic model_vector(
    input  ecc_pkg::data_t   orig,
    input  int               nflips,
    input  int               pos0,
    input  int               pos1,
    input  logic             byp,
    output ecc_pkg::data_t   rx_data,
    output ecc_pkg::parity_t rx_parity,
    output ecc_pkg::data_t   exp_mask,
    output ecc_pkg::data_t   exp_dout,
    output logic             exp_sbit,
    output logic             exp_dbit
);
    logic [CW_WIDTH-1:0] cw;

    cw = {model_parity(orig), orig};
    if (nflips >= 1) begin
        cw[pos0] = ~cw[pos0];
    end
    if (nflips == 2) begin
        cw[pos1] = ~cw[pos1];  // Caller keeps pos1 distinct from pos0
    end
    rx_data   = cw[ecc_pkg::DATA_WIDTH-1:0];
    rx_parity = cw[CW_WIDTH-1:ecc_pkg::DATA_WIDTH];

    // Only a lone data flip points at a data bit
    exp_mask = '0;
    if (nflips == 1 && pos0 < ecc_pkg::DATA_WIDTH) begin
        exp_mask[pos0] = 1'b1;
    end

    exp_sbit = !byp && (nflips == 1);
    exp_dbit = !byp && (nflips == 2);

    // A corrected lone data flip restores the original word
    exp_dout = rx_data;
    if (!byp && nflips == 1 && pos0 < ecc_pkg::DATA_WIDTH) begin
        exp_dout = orig;
    end
endtask

`endif

// ==== tb_ecc.sv ====
`timescale 1ns/100ps

module tb_ecc;

    localparam int CLK_PERIOD    = 100;
    localparam int DRIVE_DELAY   = 10;
    localparam int SAMPLE_DELAY  = 80;  // Lands 10 ns before the next rising edge
    localparam int RESET_CYCLES  = 5;

    localparam int N_CORNER      = 4;
    localparam int N_ENCODE      = 40;
    localparam int N_DATA_RAND   = 40;
    localparam int N_PARITY_RAND = 8;
    localparam int N_DOUBLE      = 60;
    localparam int N_BYPASS      = 40;
    localparam int TOTAL_VECTORS = N_CORNER + N_ENCODE + ecc_pkg::DATA_WIDTH + N_DATA_RAND
                                 + ecc_pkg::PARITY_WIDTH + N_PARITY_RAND + N_DOUBLE
                                 + N_BYPASS;
    localparam int WATCHDOG_NS   = (RESET_CYCLES + TOTAL_VECTORS + 20) * CLK_PERIOD;

    logic             clk;
    logic             arst_n;
    ecc_pkg::data_t   data_in;
    ecc_pkg::data_t   data_out;
    ecc_pkg::parity_t parity_in;
    ecc_pkg::parity_t parity_out;
    logic             bypass;
    ecc_pkg::data_t   mask;
    logic             sbit_err;
    logic             dbit_err;

    logic [31:0]      rng_state;
    int               data_errs;
    int               parity_errs;
    int               flag_errs;
    logic             timed_out;

    `include "tb_ecc_model.svh"

    ecc_89_top dut_i (
        .data_in    (data_in),
        .data_out   (data_out),
        .parity_in  (parity_in),
        .parity_out (parity_out),
        .bypass     (bypass),
        .mask       (mask),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_rand() % 32'(n));
    endfunction

    // Three draws with the top bits dropped
    function automatic ecc_pkg::data_t rand_data();
        logic [95:0] wide;

        wide = {next_rand(), next_rand(), next_rand()};
        return wide[ecc_pkg::DATA_WIDTH-1:0];
    endfunction

    function automatic ecc_pkg::data_t alt_pattern(input logic first);
        ecc_pkg::data_t d;

        for (int i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin
            d[i] = first ^ logic'(i % 2);
        end
        return d;
    endfunction

    // Two distinct codeword positions
    task automatic pick_pair(output int p0, output int p1);
        p0 = rand_below(CW_WIDTH);
        p1 = rand_below(CW_WIDTH - 1);
        if (p1 >= p0) begin
            p1 = p1 + 1;
        end
    endtask

    task automatic check_data(input string name, input ecc_pkg::data_t exp,
                              input ecc_pkg::data_t act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            data_errs++;
        end
    endtask

    task automatic check_parity(input string name, input ecc_pkg::parity_t exp,
                                input ecc_pkg::parity_t act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            parity_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s: expected %b, actual %b", name, exp, act);
            flag_errs++;
        end
    endtask

    // One vector per clock cycle
    task automatic apply_vector(input string name, input ecc_pkg::data_t orig,
                                input int nflips, input int pos0, input int pos1,
                                input logic byp);
        ecc_pkg::data_t   rx_data;
        ecc_pkg::parity_t rx_parity;
        ecc_pkg::data_t   exp_mask;
        ecc_pkg::data_t   exp_dout;
        logic             exp_sbit;
        logic             exp_dbit;

        model_vector(orig, nflips, pos0, pos1, byp, rx_data, rx_parity,
                     exp_mask, exp_dout, exp_sbit, exp_dbit);
        @(posedge clk);
        #DRIVE_DELAY;
        data_in   = rx_data;
        parity_in = rx_parity;
        bypass    = byp;
        #SAMPLE_DELAY;
        check_parity({name, " parity_out"}, model_parity(rx_data), parity_out);
        check_data({name, " mask"}, exp_mask, mask);
        check_data({name, " data_out"}, exp_dout, data_out);
        check_flag({name, " sbit_err"}, exp_sbit, sbit_err);
        check_flag({name, " dbit_err"}, exp_dbit, dbit_err);
    endtask

    task automatic check_idle_outputs();
        check_parity("reset parity_out", '0, parity_out);
        check_data("reset mask", '0, mask);
        check_data("reset data_out", '0, data_out);
        check_flag("reset sbit_err", 1'b0, sbit_err);
        check_flag("reset dbit_err", 1'b0, dbit_err);
    endtask

    task automatic finish_run();
        int total;

        total = data_errs + parity_errs + flag_errs;
        $display("Errors: data %0d, parity %0d, flag %0d, total %0d",
                 data_errs, parity_errs, flag_errs, total);
        if (total == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    // Reset release after the reset cycles
    initial begin
        repeat (RESET_CYCLES) begin
            @(posedge clk);
        end
        #DRIVE_DELAY;
        arst_n = 1'b1;
    end

    initial begin
        int p0;
        int p1;
        int nflips;

        clk         = 1'b0;
        arst_n      = 1'b0;
        data_in     = '0;
        parity_in   = '0;
        bypass      = 1'b0;
        rng_state   = 32'h8ad5;
        data_errs   = 0;
        parity_errs = 0;
        flag_errs   = 0;
        timed_out   = 1'b0;

        // All-zero inputs until reset is released
        while (!arst_n) begin
            @(posedge clk);
            #(DRIVE_DELAY + SAMPLE_DELAY);
            check_idle_outputs();
        end

        apply_vector("corner zeros", '0, 0, 0, 0, 1'b0);
        apply_vector("corner ones", '1, 0, 0, 0, 1'b0);
        apply_vector("corner alt0", alt_pattern(1'b0), 0, 0, 0, 1'b0);
        apply_vector("corner alt1", alt_pattern(1'b1), 0, 0, 0, 1'b0);

        repeat (N_ENCODE) begin
            apply_vector("encode", rand_data(), 0, 0, 0, 1'b0);
        end

        for (int i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin
            apply_vector($sformatf("single data bit %0d", i), rand_data(), 1, i, 0, 1'b0);
        end
        repeat (N_DATA_RAND) begin
            p0 = rand_below(ecc_pkg::DATA_WIDTH);
            apply_vector("single data random", rand_data(), 1, p0, 0, 1'b0);
        end

        // Check bits sit above the data bits in the codeword
        for (int j = 0; j < ecc_pkg::PARITY_WIDTH; j++) begin
            apply_vector($sformatf("single check bit %0d", j), rand_data(), 1,
                         ecc_pkg::DATA_WIDTH + j, 0, 1'b0);
        end
        repeat (N_PARITY_RAND) begin
            p0 = ecc_pkg::DATA_WIDTH + rand_below(ecc_pkg::PARITY_WIDTH);
            apply_vector("single check random", rand_data(), 1, p0, 0, 1'b0);
        end

        repeat (N_DOUBLE) begin
            pick_pair(p0, p1);
            apply_vector($sformatf("double %0d/%0d", p0, p1), rand_data(), 2, p0, p1, 1'b0);
        end

        repeat (N_BYPASS) begin
            nflips = rand_below(3);
            pick_pair(p0, p1);
            apply_vector($sformatf("bypass %0d flips", nflips), rand_data(), nflips,
                         p0, p1, 1'b1);
        end

        @(posedge clk);
        finish_run();
    end

    initial begin
        #WATCHDOG_NS;
        $display("Timeout: the test sequence did not complete in %0d ns", WATCHDOG_NS);
        timed_out = 1'b1;
        finish_run();
    end

endmodule

// ==== ecc_89_top.sv ====
`timescale 1ns/100ps

module ecc_89_top (
    input  ecc_pkg::data_t   data_in,
    output ecc_pkg::data_t   data_out,
    input  ecc_pkg::parity_t parity_in,
    output ecc_pkg::parity_t parity_out,  // Check bits of data_in as presented
    input  logic             bypass,
    output ecc_pkg::data_t   mask,
    output logic             sbit_err,
    output logic             dbit_err
);

    ecc_pkg::parity_t parity_calc;

    ecc_encoder encoder_i (
        .data   (data_in),
        .parity (parity_calc)
    );

    assign parity_out = parity_calc;

    // Same-cycle check against the received check bits
    ecc_syndrome_decoder decoder_i (
        .data_in     (data_in),
        .parity_in   (parity_in),
        .parity_calc (parity_calc),
        .bypass      (bypass),
        .data_out    (data_out),
        .mask        (mask),
        .sbit_err    (sbit_err),
        .dbit_err    (dbit_err)
    );

endmodule

// ==== ecc_syndrome_decoder.sv ====
`timescale 1ns/100ps

module ecc_syndrome_decoder (
    input  ecc_pkg::data_t   data_in,
    input  ecc_pkg::parity_t parity_in,    // Check bits as received
    input  ecc_pkg::parity_t parity_calc,  // Check bits recomputed from data_in
    input  logic             bypass,
    output ecc_pkg::data_t   data_out,
    output ecc_pkg::data_t   mask,
    output logic             sbit_err,
    output logic             dbit_err
);

    ecc_pkg::parity_t   syndrome;
    logic               chk_flip;
    logic               data_flip;
    ecc_pkg::err_class_t syn_class;

    assign syndrome = parity_in ^ parity_calc;

    // Column match per data bit
    // Columns are distinct and nonzero, so at most one bit fires
    for (genvar i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin : g_col
        assign mask[i] = (syndrome == ecc_pkg::H_COLUMNS[i]);
    end

    assign data_flip = |mask;

    // Weight-one syndrome points at a flipped check bit
    assign chk_flip = $onehot(syndrome);

    always_comb begin
        if (syndrome == '0) begin
            syn_class = ecc_pkg::ERR_NONE;
        end else if (data_flip || chk_flip) begin
            syn_class = ecc_pkg::ERR_SINGLE;
        end else begin
            // Even weight or unused odd code is uncorrectable
            syn_class = ecc_pkg::ERR_DOUBLE;
        end
    end

    // Mask itself stays visible under bypass
    assign data_out = bypass ? data_in : (data_in ^ mask);

    assign sbit_err = !bypass && (syn_class == ecc_pkg::ERR_SINGLE);
    assign dbit_err = !bypass && (syn_class == ecc_pkg::ERR_DOUBLE);

endmodule

// ==== ecc_encoder.sv ====
`timescale 1ns/100ps

module ecc_encoder (
    input  ecc_pkg::data_t   data,
    output ecc_pkg::parity_t parity
);

    // Data bits that feed check bit j
    function automatic ecc_pkg::data_t row_mask(input int j);
        ecc_pkg::data_t m;
        m = '0;
        for (int i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin
            m[i] = ecc_pkg::H_COLUMNS[i][j];
        end
        return m;
    endfunction

    // One XOR tree per check bit
    for (genvar j = 0; j < ecc_pkg::PARITY_WIDTH; j++) begin : g_check
        localparam ecc_pkg::data_t row_bits = row_mask(j);

        assign parity[j] = ^(data & row_bits);  // Even parity over the row
    end

endmodule

// ==== ecc_pkg.sv ====
package ecc_pkg;

    localparam int DATA_WIDTH   = 89;
    localparam int PARITY_WIDTH = 8;

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [PARITY_WIDTH-1:0] parity_t;  // Also used for the syndrome

    // Syndrome outcome
    typedef enum logic [1:0] {
        ERR_NONE   = 2'b00,
        ERR_SINGLE = 2'b01,
        ERR_DOUBLE = 2'b10
    } err_class_t;

    // Parity-check matrix, one column per data bit
    // Low seven bits step through non-power-of-two positions
    // Bit 7 is set where needed to keep every column at odd weight
    localparam parity_t H_COLUMNS [DATA_WIDTH] = '{
        8'b10000011,  // Bit 0
        8'b10000101,
        8'b10000110,
        8'b00000111,
        8'b10001001,
        8'b10001010,
        8'b00001011,
        8'b10001100,
        8'b00001101,
        8'b00001110,
        8'b10001111,  // Bit 10
        8'b10010001,
        8'b10010010,
        8'b00010011,
        8'b10010100,
        8'b00010101,
        8'b00010110,
        8'b10010111,
        8'b10011000,
        8'b00011001,
        8'b00011010,  // Bit 20
        8'b10011011,
        8'b00011100,
        8'b10011101,
        8'b10011110,
        8'b00011111,
        8'b10100001,  // First column using check bit 5
        8'b10100010,
        8'b00100011,
        8'b10100100,
        8'b00100101,  // Bit 30
        8'b00100110,
        8'b10100111,
        8'b10101000,
        8'b00101001,
        8'b00101010,
        8'b10101011,
        8'b00101100,
        8'b10101101,
        8'b10101110,
        8'b00101111,  // Bit 40
        8'b10110000,
        8'b00110001,
        8'b00110010,
        8'b10110011,
        8'b00110100,
        8'b10110101,
        8'b10110110,
        8'b00110111,
        8'b00111000,
        8'b10111001,  // Bit 50
        8'b10111010,
        8'b00111011,
        8'b10111100,
        8'b00111101,
        8'b00111110,
        8'b10111111,
        8'b11000001,  // First column using check bit 6
        8'b11000010,
        8'b01000011,
        8'b11000100,  // Bit 60
        8'b01000101,
        8'b01000110,
        8'b11000111,
        8'b11001000,
        8'b01001001,
        8'b01001010,
        8'b11001011,
        8'b01001100,
        8'b11001101,
        8'b11001110,  // Bit 70
        8'b01001111,
        8'b11010000,
        8'b01010001,
        8'b01010010,
        8'b11010011,
        8'b01010100,
        8'b11010101,
        8'b11010110,
        8'b01010111,
        8'b01011000,  // Bit 80
        8'b11011001,
        8'b11011010,
        8'b01011011,
        8'b11011100,
        8'b01011101,
        8'b01011110,
        8'b11011111,
        8'b11100000   // Bit 88 is the only column with both bit 5 and bit 6
    };

endpackage
